/* hw/bram_pkg.sv */
// memory map, widths and address views shared by the APB boot RAM design
package bram_pkg;

   localparam int apb_addr_width  = 32;
   localparam int word_width      = 32;
   localparam int strb_width      = word_width / 8;
   localparam int line_width      = 128;
   localparam int line_bytes      = line_width / 8;
   localparam int lanes_per_line  = line_width / word_width;
   localparam int bram_addr_width = 16;  // 64 KB
   localparam int line_offset     = $clog2(line_bytes);
   localparam int line_count      = 2 ** (bram_addr_width - line_offset);

   localparam logic [apb_addr_width-1:0] bram_base = 32'h0000_0000;
   localparam logic [apb_addr_width-1:0] bram_mask = 32'h0000_ffff;

   typedef logic [strb_width-1:0] strb_t;
   typedef logic [line_width-1:0] line_t;
   typedef logic [line_bytes-1:0] line_we_t;

   // line / lane / byte split of a RAM byte address
   typedef struct packed {
      logic [bram_addr_width-line_offset-1:0] line;
      logic [$clog2(lanes_per_line)-1:0]      lane;
      logic [$clog2(strb_width)-1:0]          offset;
   } addr_fields_t;

   typedef union packed {
      logic [bram_addr_width-1:0] flat;
      addr_fields_t               fields;
   } ram_addr_t;

endpackage

/* hw/lane_req_if.sv */
// word-wide request from the APB front end to the lane steerer, one pulse per access
interface lane_req_if;
   import bram_pkg::*;

   logic                  valid;  // single cycle, always taken
   logic                  write;
   ram_addr_t             addr;
   logic [word_width-1:0] wdata;
   strb_t                 strb;
   logic [word_width-1:0] rdata;  // one cycle after valid

   modport front (
      output valid,
      output write,
      output addr,
      output wdata,
      output strb,
      input  rdata
   );

   modport steer (
      input  valid,
      input  write,
      input  addr,
      input  wdata,
      input  strb,
      output rdata
   );

endinterface

/* hw/ram_port_if.sv */
// line-wide block RAM port between the lane steerer and the line store
interface ram_port_if;
   import bram_pkg::*;

   logic      en;
   line_we_t  we;      // one bit per byte of the line
   ram_addr_t addr;
   line_t     wrdata;
   line_t     rddata;

   modport steer (
      output en,
      output we,
      output addr,
      output wrdata,
      input  rddata
   );

   modport store (
      input  en,
      input  we,
      input  addr,
      input  wrdata,
      output rddata
   );

endinterface

/* hw/apb_slave_port.sv */
// APB slave front end: decodes the RAM region and turns each hit into one lane request
module apb_slave_port (
   input  logic                                ram_clk,
   input  logic                                reset_i,
   input  logic                                psel_i,
   input  logic                                penable_i,
   input  logic                                pwrite_i,
   input  logic [bram_pkg::apb_addr_width-1:0] paddr_i,
   input  logic [bram_pkg::word_width-1:0]     pwdata_i,
   input  bram_pkg::strb_t                     pstrb_i,
   output logic [bram_pkg::word_width-1:0]     prdata_o,
   output logic                                pready_o,
   output logic                                pslverr_o,
   lane_req_if.front                           req
);
   import bram_pkg::*;

   logic wait_q;     // high in the second access cycle
   logic err_q;
   logic hit;
   logic first_access;

   assign hit          = (paddr_i & ~bram_mask) == bram_base;
   assign first_access = psel_i & penable_i & ~wait_q;

   // the single wait state, same for every transfer
   always_ff @(posedge ram_clk) begin
      if (reset_i) begin
         wait_q <= 1'b0;
         err_q  <= 1'b0;
      end else if (wait_q) begin
         wait_q <= 1'b0;  // transfer completes this cycle
         err_q  <= 1'b0;
      end else if (first_access) begin
         wait_q <= 1'b1;
         err_q  <= ~hit;
      end
   end

   // request goes out in the first access cycle, misses never reach the RAM
   assign req.valid      = first_access & hit;
   assign req.write      = pwrite_i;
   assign req.addr.flat  = paddr_i[bram_addr_width-1:0];
   assign req.wdata      = pwdata_i;
   assign req.strb       = pstrb_i;

   assign pready_o  = wait_q;
   assign pslverr_o = err_q;

   // zero data on errors and outside the ready cycle
   always_comb begin
      if (wait_q && !err_q && !pwrite_i) begin
         prdata_o = req.rdata;
      end else begin
         prdata_o = '0;
      end
   end

endmodule

/* hw/lane_steer.sv */
// places a 32-bit word request on its lane of the 128-bit RAM line and picks the lane back out
module lane_steer (
   input  logic       ram_clk,
   input  logic       reset_i,
   lane_req_if.steer  req,
   ram_port_if.steer  ram
);
   import bram_pkg::*;

   logic [$clog2(lanes_per_line)-1:0] lane_q;

   assign ram.en     = req.valid;
   assign ram.addr   = req.addr;
   assign ram.wrdata = {lanes_per_line{req.wdata}};  // same word in every lane

   // strobes shifted up to the addressed lane, nothing enabled on reads
   always_comb begin
      if (req.write) begin
         ram.we = line_we_t'(req.strb) << (req.addr.fields.lane * strb_width);
      end else begin
         ram.we = '0;
      end
   end

   // lane follows the registered read address of the store
   always_ff @(posedge ram_clk) begin
      if (reset_i) begin
         lane_q <= '0;
      end else if (req.valid) begin
         lane_q <= req.addr.fields.lane;
      end
   end

   assign req.rdata = ram.rddata[lane_q*word_width +: word_width];

endmodule

/* hw/bram_line_store.sv */
// inferred block RAM of 128-bit lines with byte write enables and a registered read address
module bram_line_store (
   input  logic      ram_clk,
   ram_port_if.store ram
);
   import bram_pkg::*;

   line_t ram_q [0:line_count-1];
   logic [bram_addr_width-line_offset-1:0] line_dly;

   always_ff @(posedge ram_clk) begin
      if (ram.en) begin
         line_dly <= ram.addr.fields.line;
         for (int i = 0; i < line_bytes; i++) begin
            if (ram.we[i]) begin
               ram_q[ram.addr.fields.line][i*8 +: 8] <= ram.wrdata[i*8 +: 8];
            end
         end
      end
   end

   assign ram.rddata = ram_q[line_dly];  // one cycle after en

endmodule

/* hw/apb_bram_top.sv */
// top level of the APB boot RAM: plain APB pins wired to front end, lane steerer and RAM
module apb_bram_top (
   input  logic                                ram_clk,
   input  logic                                reset_i,
   input  logic                                psel_i,
   input  logic                                penable_i,
   input  logic                                pwrite_i,
   input  logic [bram_pkg::apb_addr_width-1:0] paddr_i,
   input  logic [bram_pkg::word_width-1:0]     pwdata_i,
   input  bram_pkg::strb_t                     pstrb_i,
   output logic [bram_pkg::word_width-1:0]     prdata_o,
   output logic                                pready_o,
   output logic                                pslverr_o
);

   lane_req_if lane_req ();
   ram_port_if ram_port ();

   apb_slave_port u_front (
      .ram_clk   (ram_clk),
      .reset_i   (reset_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .pstrb_i   (pstrb_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .req       (lane_req)
   );

   lane_steer u_steer (
      .ram_clk (ram_clk),
      .reset_i (reset_i),
      .req     (lane_req),
      .ram     (ram_port)
   );

   bram_line_store u_store (
      .ram_clk (ram_clk),
      .ram     (ram_port)
   );

endmodule

/* verification/apb_bram_assertions.sv */
// APB timing properties, bound onto the boot RAM top level for every simulation
module apb_bram_assertions (
   input logic ram_clk,
   input logic reset_i,
   input logic psel_i,
   input logic penable_i,
   input logic pready_o,
   input logic pslverr_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // ready only inside an access cycle
   ready_in_access: assert property (@(posedge ram_clk) disable iff (reset_i)
      pready_o |-> (psel_i && penable_i))
      else $error("pready high outside an APB access cycle");

   // one wait state after every setup cycle
   one_wait_state: assert property (@(posedge ram_clk) disable iff (reset_i)
      (psel_i && !penable_i) |=> !pready_o ##1 pready_o)
      else $error("pready not low then high in the two access cycles");

   error_with_ready: assert property (@(posedge ram_clk) disable iff (reset_i)
      pslverr_o |-> pready_o)
      else $error("pslverr high without pready");

endmodule

bind apb_bram_top apb_bram_assertions u_apb_checks (
   .ram_clk   (ram_clk),
   .reset_i   (reset_i),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pready_o  (pready_o),
   .pslverr_o (pslverr_o)
);

/* verification/apb_bram_tb.sv */
// self-checking testbench that runs random APB traffic on the boot RAM against a byte model
module apb_bram_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import bram_pkg::*;

   localparam int window_words = 64;
   localparam int xfer_timeout = 20;

   logic                      ram_clk;
   logic                      reset_i;
   logic                      psel_i;
   logic                      penable_i;
   logic                      pwrite_i;
   logic [apb_addr_width-1:0] paddr_i;
   logic [word_width-1:0]     pwdata_i;
   strb_t                     pstrb_i;
   logic [word_width-1:0]     prdata_o;
   logic                      pready_o;
   logic                      pslverr_o;

   logic [7:0] model_mem [0:window_words*4-1];  // byte image of the window

   apb_bram_top DUT (
      .ram_clk   (ram_clk),
      .reset_i   (reset_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .pstrb_i   (pstrb_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o)
   );

   always #5 ram_clk = ~ram_clk;

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s expected %h actual %h", test_name, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   function automatic logic [31:0] model_word(input int idx);
      return {model_mem[idx*4+3], model_mem[idx*4+2], model_mem[idx*4+1], model_mem[idx*4]};
   endfunction

   // setup, access until pready, then hold across the sampling edge
   task automatic apb_transfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               output logic [31:0] rdata, output logic err);
      int cycles;
      @(negedge ram_clk);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = write;
      paddr_i   = addr;
      pwdata_i  = wdata;
      pstrb_i   = strb;
      cycles    = 0;
      @(negedge ram_clk);
      penable_i = 1'b1;
      cycles    = 1;
      while (pready_o !== 1'b1) begin
         check_value("pslverr without pready", 32'd0, {31'd0, pslverr_o});
         if (cycles >= xfer_timeout) begin
            $display("timeout: no pready within %0d cycles at address %h", xfer_timeout, addr);
            $display(">>> FAIL");
            $fatal(1, "APB transfer timed out");
         end
         @(negedge ram_clk);
         cycles++;
      end
      rdata = prdata_o;
      err   = pslverr_o;
      check_value("ready cycles", 32'd2, cycles);
      @(negedge ram_clk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic write_word(input int idx, input logic [31:0] data, input logic [3:0] strb);
      logic [31:0] rdata;
      logic        err;
      apb_transfer(1'b1, idx * 4, data, strb, rdata, err);
      check_value("write error", 32'd0, {31'd0, err});
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            model_mem[idx*4+b] = data[b*8 +: 8];
         end
      end
   endtask

   task automatic read_check(input string test_name, input int idx);
      logic [31:0] rdata;
      logic        err;
      apb_transfer(1'b0, idx * 4, 32'd0, 4'h0, rdata, err);
      check_value({test_name, " pslverr"}, 32'd0, {31'd0, err});
      check_value(test_name, model_word(idx), rdata);
   endtask

   initial begin
      logic [31:0] addr;
      logic [31:0] rdata;
      logic        err;
      int          idx;
      int          line_idx;
      void'($urandom(32'hf70b));
      ram_clk   = 1'b0;
      reset_i   = 1'b1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      pstrb_i   = '0;
      repeat (10) @(negedge ram_clk);
      reset_i = 1'b0;
      @(negedge ram_clk);
      check_value("pready after reset", 32'd0, {31'd0, pready_o});
      check_value("pslverr after reset", 32'd0, {31'd0, pslverr_o});

      // RAM starts unknown so the whole window gets written first
      for (int i = 0; i < window_words; i++) begin
         write_word(i, $urandom, 4'hf);
      end
      for (int i = 0; i < window_words; i++) begin
         read_check("init readback", i);
      end

      for (int n = 0; n < 300; n++) begin
         idx = $urandom_range(window_words - 1, 0);
         if ($urandom_range(1, 0) == 1) begin
            write_word(idx, $urandom, 4'($urandom_range(15, 0)));  // zero strobe too
         end else begin
            read_check("random partial", idx);
         end
      end

      // one lane written, the whole line read back
      for (int n = 0; n < 16; n++) begin
         line_idx = $urandom_range(window_words / 4 - 1, 0);
         write_word(line_idx * 4 + $urandom_range(3, 0), $urandom, 4'hf);
         for (int l = 0; l < 4; l++) begin
            read_check("lane isolation", line_idx * 4 + l);
         end
      end

      for (int n = 0; n < 20; n++) begin
         // low half aliases the window so a leaked write shows up
         addr = {16'($urandom_range(16'hffff, 1)), 16'($urandom_range(window_words - 1, 0) * 4)};
         apb_transfer(1'($urandom_range(1, 0)), addr, $urandom, 4'hf, rdata, err);
         check_value("miss pslverr", 32'd1, {31'd0, err});
         check_value("miss prdata", 32'd0, rdata);
      end
      for (int i = 0; i < window_words; i++) begin
         read_check("after misses", i);
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

/* list.f */
hw/bram_pkg.sv
hw/lane_req_if.sv
hw/ram_port_if.sv
hw/apb_slave_port.sv
hw/lane_steer.sv
hw/bram_line_store.sv
hw/apb_bram_top.sv
verification/apb_bram_assertions.sv
verification/apb_bram_tb.sv
